// File: filelist.f
source/gb_cart_pkg.sv
source/gb_cart_ifs.sv
source/cart_header_capture.sv
source/mbc_bank_regs.sv
source/cart_bus_decode.sv
source/cart_ram.sv
source/gb_cart_top.sv
tests/tb_gb_cart.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cartridge mapper testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f filelist.f --top-module tb_gb_cart -o tb_gb_cart
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_gb_cart > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' sim.log; then
	exit 1
fi
exit 0

// File: source/cart_bus_decode.sv
// cart_bus_decode: rom word address, cart ram address/write, console read data select
module cart_bus_decode import gb_cart_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   bus_rd,
	input  logic                   bus_wr,
	input  logic [CART_ADDR_W-1:0] bus_addr,
	cart_info_if.sink              info,
	bank_state_if.sink             banks,
	output logic [ROM_ADDR_W-1:0]  rom_addr,
	input  logic [DL_DATA_W-1:0]   rom_data,
	output logic [CRAM_ADDR_W-1:0] cram_addr,
	output logic                   cram_we,
	input  logic [CART_DATA_W-1:0] cram_q,
	output logic [CART_DATA_W-1:0] bus_rdata
);

	logic [2:0]            region;
	logic [ROM_BANK_W-1:0] rom_bank_eff; // bank before masking
	logic [ROM_BANK_W-1:0] rom_bank_sel; // bank driven to the rom
	logic [RAM_BANK_W-1:0] ram_bank_eff;
	logic                  mbc2_nibble;  // mbc2 internal 512x4 window

	assign region = bus_addr[15:13];

	// ----------------------------------------------------------------------
	// rom mapping
	// ----------------------------------------------------------------------
	always_comb begin
		case (info.mbc_kind)
			// mode 0: ram bank bits act as rom bank bits 6..5
			MBC_1:   rom_bank_eff = {2'b00, (banks.mbc1_mode ? 2'b00 : banks.ram_bank[1:0]),
				banks.rom_bank[4:0]};
			default: rom_bank_eff = banks.rom_bank;
		endcase
	end

	assign rom_bank_sel = bus_addr[14] ? (rom_bank_eff & info.rom_mask) : '0; // 0000-3FFF fixed

	// word address, so the byte lane comes from bit 0
	assign rom_addr = (info.mbc_kind == MBC_NONE) ?
		{{(ROM_ADDR_W-14){1'b0}}, bus_addr[14:1]} :               // flat 32K
		{{(ROM_ADDR_W-ROM_BANK_W-13){1'b0}}, rom_bank_sel, bus_addr[13:1]};

	// ----------------------------------------------------------------------
	// cartridge ram mapping
	// ----------------------------------------------------------------------
	always_comb begin
		case (info.mbc_kind)
			MBC_1:        ram_bank_eff = banks.mbc1_mode ? banks.ram_bank : '0; // banked in mode 1
			MBC_3, MBC_5: ram_bank_eff = banks.ram_bank;
			default:      ram_bank_eff = '0;                                    // single 8K
		endcase
	end

	assign cram_addr   = {ram_bank_eff & info.ram_mask, bus_addr[12:0]};
	assign cram_we     = bus_wr & (region == REGION_CRAM) & banks.ram_enable;
	assign mbc2_nibble = (info.mbc_kind == MBC_2) && (bus_addr[15:9] == 7'b1010000);

	// ----------------------------------------------------------------------
	// read data, selected one cycle after the strobe then held
	// ----------------------------------------------------------------------
	logic [2:0]             rd_region;
	logic                   rd_hi;       // odd byte of the rom word
	logic                   rd_ram_off;
	logic                   rd_rtc;
	logic                   rd_nibble;
	logic                   rd_pend;     // rom_data / cram_q valid this cycle
	logic [CART_DATA_W-1:0] rd_hold;
	logic [CART_DATA_W-1:0] rd_byte;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_region  <= '0;
			rd_hi      <= 1'b0;
			rd_ram_off <= 1'b0;
			rd_rtc     <= 1'b0;
			rd_nibble  <= 1'b0;
			rd_pend    <= 1'b0;
			rd_hold    <= '0;
		end else begin
			rd_pend <= bus_rd;
			if (bus_rd) begin
				rd_region  <= region;
				rd_hi      <= bus_addr[0];
				rd_ram_off <= ~banks.ram_enable;
				rd_rtc     <= banks.rtc_mode;
				rd_nibble  <= mbc2_nibble;
			end
			if (rd_pend) rd_hold <= rd_byte; // keep it once the sources move on
		end
	end

	always_comb begin
		if (rd_region != REGION_CRAM)
			rd_byte = rd_hi ? rom_data[15:8] : rom_data[7:0];
		else if (rd_ram_off)
			rd_byte = RAM_OFF_DATA;
		else if (rd_rtc)
			rd_byte = '0;                 // rtc registers not modelled
		else if (rd_nibble)
			rd_byte = {4'hF, cram_q[3:0]}; // only 4 bits exist on mbc2
		else
			rd_byte = cram_q;
	end

	assign bus_rdata = rd_pend ? rd_byte : rd_hold;

	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(bus_rd && bus_wr));

endmodule

// File: source/cart_header_capture.sv
// cart_header_capture: grabs type and size bytes from the download, decodes kind and masks
module cart_header_capture import gb_cart_pkg::*; (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 dl_active,
	input  logic                 dl_wr,
	input  logic [DL_ADDR_W-1:0] dl_addr,
	input  logic [DL_DATA_W-1:0] dl_data,
	cart_info_if.source          info
);

	// cartridge type byte -> controller kind
	function automatic logic [MBC_KIND_W-1:0] kind_of(input logic [7:0] cart_type);
		case (cart_type)
			8'd1, 8'd2, 8'd3:                     kind_of = MBC_1;
			8'd5, 8'd6:                           kind_of = MBC_2;
			8'd15, 8'd16, 8'd17, 8'd18, 8'd19:    kind_of = MBC_3;
			8'd25, 8'd26, 8'd27, 8'd28, 8'd29,
			8'd30:                                kind_of = MBC_5;
			default:                              kind_of = MBC_NONE; // mmm01, huc etc. unsupported
		endcase
	endfunction

	// rom size code n -> 2^(n+1) banks, odd codes ($52..$54) fold to 128
	function automatic logic [ROM_BANK_W-1:0] rom_mask_of(input logic [7:0] code);
		if (code <= 8'd8)
			rom_mask_of = ROM_BANK_W'((10'd2 << code[3:0]) - 10'd1);
		else
			rom_mask_of = ROM_BANK_W'(127);
	endfunction

	// ram size code: up to 8K is one bank, 32K four, otherwise sixteen
	function automatic logic [RAM_BANK_W-1:0] ram_mask_of(input logic [7:0] code);
		if (code <= 8'd2)
			ram_mask_of = '0;
		else if (code == 8'd3)
			ram_mask_of = RAM_BANK_W'(3);
		else
			ram_mask_of = '1;
	endfunction

	logic hdr_wr;

	assign hdr_wr = dl_active & dl_wr;

	// decoded fields are kept registered, so the sink sees them one cycle after the word
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			info.mbc_kind <= MBC_NONE;
			info.rom_mask <= '0;
			info.ram_mask <= '0;
		end else if (hdr_wr) begin
			if (dl_addr == HDR_TYPE_ADDR)
				info.mbc_kind <= kind_of(dl_data[15:8]); // type is the odd byte
			if (dl_addr == HDR_SIZE_ADDR) begin
				info.rom_mask <= rom_mask_of(dl_data[7:0]);
				info.ram_mask <= ram_mask_of(dl_data[15:8]);
			end
		end
	end

	// the loader only strobes inside a download window
	a_wr_in_download: assert property (@(posedge clk_sys) disable iff (reset)
		dl_wr |-> dl_active);

endmodule

// File: source/cart_ram.sv
// cart_ram: 128 KB byte-wide cartridge ram, synchronous write and registered read
module cart_ram import gb_cart_pkg::*; (
	input  logic                   clk_sys,
	input  logic [CRAM_ADDR_W-1:0] cram_addr,
	input  logic                   cram_we,
	input  logic [CART_DATA_W-1:0] bus_wdata,
	output logic [CART_DATA_W-1:0] cram_q
);

	localparam int DEPTH = 1 << CRAM_ADDR_W; // 16 banks of 8K

	logic [CART_DATA_W-1:0] mem [0:DEPTH-1];

	// single port, read returns the old byte on a write cycle
	always_ff @(posedge clk_sys) begin
		if (cram_we)
			mem[cram_addr] <= bus_wdata; // gated upstream by ram enable
		cram_q <= mem[cram_addr];
	end

endmodule

// File: source/gb_cart_ifs.sv
// interfaces: cart_info_if (decoded header) and bank_state_if (mbc registers)

// header decode results, held until the next download
interface cart_info_if import gb_cart_pkg::*; ();
	logic [MBC_KIND_W-1:0] mbc_kind; // which controller
	logic [ROM_BANK_W-1:0] rom_mask; // rom bank bits that exist
	logic [RAM_BANK_W-1:0] ram_mask; // ram bank bits that exist

	modport source (
		output mbc_kind,
		output rom_mask,
		output ram_mask
	);

	modport sink (
		input mbc_kind,
		input rom_mask,
		input ram_mask
	);
endinterface

// current bank register state as written by the console
interface bank_state_if import gb_cart_pkg::*; ();
	logic [ROM_BANK_W-1:0] rom_bank;
	logic [RAM_BANK_W-1:0] ram_bank;
	logic                  mbc1_mode;  // 0: ram bank bits extend the rom bank
	logic                  rtc_mode;   // mbc3 rtc register mapped at A000
	logic                  ram_enable;

	modport source (
		output rom_bank, ram_bank, mbc1_mode, rtc_mode, ram_enable
	);

	modport sink (
		input rom_bank, ram_bank, mbc1_mode, rtc_mode, ram_enable
	);
endinterface

// File: source/gb_cart_pkg.sv
// package: bus widths, controller codes, header offsets, region codes, bus constants
package gb_cart_pkg;

	// ----------------------------------------------------------------------
	// widths
	// ----------------------------------------------------------------------
	localparam int CART_ADDR_W = 16; // console address
	localparam int CART_DATA_W = 8;  // console data
	localparam int DL_ADDR_W   = 25; // download byte address
	localparam int DL_DATA_W   = 16; // download word, also the external rom word
	localparam int ROM_BANK_W  = 9;  // up to 512 banks of 16K (mbc5)
	localparam int RAM_BANK_W  = 4;  // up to 16 banks of 8K
	localparam int ROM_ADDR_W  = 24; // external rom word address
	localparam int CRAM_ADDR_W = 17; // 128 KB cartridge ram, byte address
	localparam int MBC_KIND_W  = 3;

	// ----------------------------------------------------------------------
	// controller kinds
	// ----------------------------------------------------------------------
	localparam logic [MBC_KIND_W-1:0] MBC_NONE = 3'd0; // plain 32K rom
	localparam logic [MBC_KIND_W-1:0] MBC_1    = 3'd1;
	localparam logic [MBC_KIND_W-1:0] MBC_2    = 3'd2; // built-in 512x4 ram
	localparam logic [MBC_KIND_W-1:0] MBC_3    = 3'd3; // rtc capable
	localparam logic [MBC_KIND_W-1:0] MBC_5    = 3'd4; // 9-bit rom bank

	// ----------------------------------------------------------------------
	// cartridge header, byte addresses in the download stream
	// ----------------------------------------------------------------------
	// type sits in the upper byte of the word at 146
	localparam logic [DL_ADDR_W-1:0] HDR_TYPE_ADDR = 25'h146;
	// word at 148: ram size code high, rom size code low
	localparam logic [DL_ADDR_W-1:0] HDR_SIZE_ADDR = 25'h148;

	// ----------------------------------------------------------------------
	// console address regions, bits 15..13
	// ----------------------------------------------------------------------
	localparam logic [2:0] REGION_RAM_EN   = 3'd0; // 0000-1FFF
	localparam logic [2:0] REGION_ROM_BANK = 3'd1; // 2000-3FFF
	localparam logic [2:0] REGION_RAM_BANK = 3'd2; // 4000-5FFF
	localparam logic [2:0] REGION_MODE     = 3'd3; // 6000-7FFF
	localparam logic [2:0] REGION_CRAM     = 3'd5; // A000-BFFF

	// misc bus constants
	localparam logic [3:0]             RAM_ENABLE_KEY = 4'hA;
	localparam logic [CART_DATA_W-1:0] RAM_OFF_DATA   = 8'hFF; // open bus when ram off

endpackage

// File: source/gb_cart_top.sv
// gb_cart_top: header capture, bank registers, bus decode and cartridge ram
module gb_cart_top import gb_cart_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,

	// cartridge download
	input  logic                   dl_active,
	input  logic                   dl_wr,
	input  logic [DL_ADDR_W-1:0]   dl_addr,
	input  logic [DL_DATA_W-1:0]   dl_data,

	// console bus
	input  logic                   bus_rd,
	input  logic                   bus_wr,
	input  logic [CART_ADDR_W-1:0] bus_addr,
	input  logic [CART_DATA_W-1:0] bus_wdata,
	output logic [CART_DATA_W-1:0] bus_rdata,

	// external rom, one word per address, one cycle latency
	output logic [ROM_ADDR_W-1:0]  rom_addr,
	input  logic [DL_DATA_W-1:0]   rom_data
);

	cart_info_if  cart_info ();
	bank_state_if bank_state ();

	logic [CRAM_ADDR_W-1:0] cram_addr;
	logic                   cram_we;
	logic [CART_DATA_W-1:0] cram_q;

	cart_header_capture cart_header_capture_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.info      (cart_info.source)
	);

	mbc_bank_regs mbc_bank_regs_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.bus_wr    (bus_wr),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.info      (cart_info.sink),
		.banks     (bank_state.source)
	);

	cart_bus_decode cart_bus_decode_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.bus_rd    (bus_rd),
		.bus_wr    (bus_wr),
		.bus_addr  (bus_addr),
		.info      (cart_info.sink),
		.banks     (bank_state.sink),
		.rom_addr  (rom_addr),
		.rom_data  (rom_data),
		.cram_addr (cram_addr),
		.cram_we   (cram_we),
		.cram_q    (cram_q),
		.bus_rdata (bus_rdata)
	);

	cart_ram cart_ram_inst (
		.clk_sys   (clk_sys),
		.cram_addr (cram_addr),
		.cram_we   (cram_we),
		.bus_wdata (bus_wdata),
		.cram_q    (cram_q)
	);

endmodule

// File: source/mbc_bank_regs.sv
// mbc_bank_regs: console-written rom/ram bank, mode and ram enable registers
module mbc_bank_regs import gb_cart_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   dl_active,
	input  logic                   bus_wr,
	input  logic [CART_ADDR_W-1:0] bus_addr,
	input  logic [CART_DATA_W-1:0] bus_wdata,
	cart_info_if.sink              info,
	bank_state_if.source           banks
);

	logic [ROM_BANK_W-1:0] rom_bank;
	logic [RAM_BANK_W-1:0] ram_bank;
	logic                  mbc1_mode;
	logic                  rtc_mode;
	logic                  ram_enable;

	logic [2:0] region; // address bits 15..13
	logic       is_mbc1;
	logic       is_mbc3;
	logic       is_mbc5;

	assign region  = bus_addr[15:13];
	assign is_mbc1 = (info.mbc_kind == MBC_1);
	assign is_mbc3 = (info.mbc_kind == MBC_3);
	assign is_mbc5 = (info.mbc_kind == MBC_5);

	// ----------------------------------------------------------------------
	// register writes, held at reset values while a cartridge loads
	// ----------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset || dl_active) begin
			rom_bank   <= ROM_BANK_W'(1); // bank 1 visible at 4000 from the start
			ram_bank   <= '0;
			mbc1_mode  <= 1'b0;
			rtc_mode   <= 1'b0;
			ram_enable <= 1'b0;
		end else if (bus_wr) begin
			case (region)
				REGION_RAM_EN: ram_enable <= (bus_wdata[3:0] == RAM_ENABLE_KEY);

				REGION_ROM_BANK: begin
					if (is_mbc5) begin
						if (bus_addr[12])             // 3000-3FFF: bank bit 8
							rom_bank[8] <= bus_wdata[0];
						else                          // 2000-2FFF: low byte, 0 allowed
							rom_bank[7:0] <= bus_wdata;
					end else if (bus_wdata[6:0] == 7'd0) begin
						rom_bank <= ROM_BANK_W'(1);   // mbc1-3 cannot select bank 0 here
					end else begin
						rom_bank <= {2'b00, bus_wdata[6:0]};
					end
				end

				REGION_RAM_BANK: begin
					if (is_mbc3) begin
						if (bus_wdata[3]) begin
							rtc_mode <= 1'b1;         // 08-0C pick an rtc register
						end else begin
							rtc_mode <= 1'b0;
							ram_bank <= {2'b00, bus_wdata[1:0]};
						end
					end else if (is_mbc5) begin
						ram_bank <= bus_wdata[3:0];   // 16 banks
					end else begin
						ram_bank <= {2'b00, bus_wdata[1:0]};
					end
				end

				REGION_MODE: if (is_mbc1) mbc1_mode <= bus_wdata[0];

				default: ; // other regions are not registers
			endcase
		end
	end

	assign banks.rom_bank   = rom_bank;
	assign banks.ram_bank   = ram_bank;
	assign banks.mbc1_mode  = mbc1_mode;
	assign banks.rtc_mode   = rtc_mode;
	assign banks.ram_enable = ram_enable;

	// zero-to-one fixup must hold across kind changes coming from the header side
	a_bank_nonzero: assert property (@(posedge clk_sys) disable iff (reset)
		(info.mbc_kind != MBC_5) |-> (rom_bank[6:0] != 7'd0));

endmodule

// File: tests/tb_gb_cart.sv
// testbench for gb_cart_top with clock, rom model, lcg, compare tasks, directed tests and timeout
module tb_gb_cart import gb_cart_pkg::*; ();

	localparam logic [31:0] SEED           = 32'h834d22e8;
	localparam int          TIMEOUT_CYCLES = 5000; // full run needs a few hundred cycles

	logic                   clk_sys  = 1'b0;
	logic                   reset;
	logic                   dl_active;
	logic                   dl_wr;
	logic [DL_ADDR_W-1:0]   dl_addr;
	logic [DL_DATA_W-1:0]   dl_data;
	logic                   bus_rd;
	logic                   bus_wr;
	logic [CART_ADDR_W-1:0] bus_addr;
	logic [CART_DATA_W-1:0] bus_wdata;
	logic [CART_DATA_W-1:0] bus_rdata;
	logic [ROM_ADDR_W-1:0]  rom_addr;
	logic [DL_DATA_W-1:0]   rom_data = '0;

	int          errors       = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;
	int          cycle_count  = 0;
	logic [31:0] lcg_state    = SEED; // byte stream for ram data

	always #2 clk_sys = ~clk_sys;

	gb_cart_top gb_cart_top_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.bus_rd    (bus_rd),
		.bus_wr    (bus_wr),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bus_rdata (bus_rdata),
		.rom_addr  (rom_addr),
		.rom_data  (rom_data)
	);

	// ----------------------------------------------------------------------
	// lcg, rom contents and expected addresses
	// ----------------------------------------------------------------------
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [7:0] rand_byte();
		lcg_state = lcg_next(lcg_state);
		return lcg_state[23:16];
	endfunction

	// every word is a scramble of its full address
	function automatic logic [15:0] rom_word(input logic [ROM_ADDR_W-1:0] a);
		logic [31:0] s;
		s = lcg_next(lcg_next(SEED ^ {8'h00, a}));
		return s[31:16];
	endfunction

	// word address of a byte inside a 16K bank
	function automatic logic [ROM_ADDR_W-1:0] banked_word(input int bank,
		input logic [15:0] addr);
		return ROM_ADDR_W'((bank * 16384 + int'(addr[13:0])) / 2);
	endfunction

	function automatic logic [ROM_ADDR_W-1:0] flat_word(input logic [15:0] addr);
		return ROM_ADDR_W'(int'(addr[14:0]) / 2); // plain 32K cartridge
	endfunction

	// external rom model with one cycle of latency
	always @(posedge clk_sys) rom_data <= rom_word(rom_addr);

	// ----------------------------------------------------------------------
	// compare tasks
	// ----------------------------------------------------------------------
	task automatic check_rom_addr(input logic [ROM_ADDR_W-1:0] exp,
		input logic [ROM_ADDR_W-1:0] act);
		if (act !== exp) begin
			errors++;
			$display("[FAIL] t=%0t rom_addr expected %h got %h", $time, exp, act);
		end
	endtask

	task automatic check_rdata(input logic [CART_DATA_W-1:0] exp,
		input logic [CART_DATA_W-1:0] act);
		if (act !== exp) begin
			errors++;
			$display("[FAIL] t=%0t bus_rdata expected %h got %h", $time, exp, act);
		end
	endtask

	// ----------------------------------------------------------------------
	// bus and download drivers that act on the falling edge
	// ----------------------------------------------------------------------
	task automatic load_header(input logic [7:0] cart_type, input logic [7:0] rom_code,
		input logic [7:0] ram_code);
		@(negedge clk_sys);
		dl_active = 1'b1;
		dl_wr     = 1'b1;
		dl_addr   = HDR_TYPE_ADDR;
		dl_data   = {cart_type, 8'h00}; // type is the upper byte
		@(negedge clk_sys);
		dl_addr   = HDR_SIZE_ADDR;
		dl_data   = {ram_code, rom_code};
		@(negedge clk_sys);
		dl_wr     = 1'b0;
		@(negedge clk_sys);
		dl_active = 1'b0;
	endtask

	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
		@(negedge clk_sys);
		bus_wr    = 1'b1;
		bus_addr  = addr;
		bus_wdata = data;
		@(negedge clk_sys);
		bus_wr    = 1'b0;
	endtask

	// word address checked at the strobe edge and the byte one cycle later
	// and once more after the address has moved away
	task automatic check_rom_read(input logic [15:0] addr,
		input logic [ROM_ADDR_W-1:0] word_addr);
		logic [15:0] w;
		logic [7:0]  exp_byte;
		w        = rom_word(word_addr);
		exp_byte = addr[0] ? w[15:8] : w[7:0];
		@(negedge clk_sys);
		bus_rd   = 1'b1;
		bus_addr = addr;
		@(posedge clk_sys);
		check_rom_addr(word_addr, rom_addr);
		@(negedge clk_sys);
		check_rdata(exp_byte, bus_rdata);
		bus_rd   = 1'b0;
		bus_addr = ~addr;                 // rom word changes, the read byte must not
		@(negedge clk_sys);
		check_rdata(exp_byte, bus_rdata);
	endtask

	task automatic check_ram_read(input logic [15:0] addr, input logic [7:0] exp);
		@(negedge clk_sys);
		bus_rd   = 1'b1;
		bus_addr = addr;
		@(negedge clk_sys);
		check_rdata(exp, bus_rdata);
		bus_rd = 1'b0;
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d mismatches", name, errors - errors_before);
		end
	endtask

	// ----------------------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------------------
	task automatic test_no_mbc();
		int e;
		e = errors;
		check_rdata(8'h00, bus_rdata); // nothing read yet
		check_rom_read(16'h0000, flat_word(16'h0000));
		check_rom_read(16'h0001, flat_word(16'h0001));
		check_rom_read(16'h4567, flat_word(16'h4567));
		check_rom_read(16'h7FFE, flat_word(16'h7FFE));
		report_test("reset and no mbc", e);
	endtask

	task automatic test_mbc1_rom();
		int e;
		e = errors;
		load_header(8'd1, 8'd4, 8'd0);                      // 512K rom with mask 31
		check_rom_read(16'h4000, banked_word(1, 16'h4000)); // bank 1 after load
		bus_write(16'h2000, 8'd0);
		check_rom_read(16'h4123, banked_word(1, 16'h4123)); // zero selects bank 1
		bus_write(16'h2000, 8'd5);
		check_rom_read(16'h5FFF, banked_word(5, 16'h5FFF));
		bus_write(16'h2000, 8'd40);
		check_rom_read(16'h7ABC, banked_word(8, 16'h7ABC)); // 40 cut to 8
		check_rom_read(16'h1235, banked_word(0, 16'h1235)); // fixed bank 0
		bus_write(16'h2000, 8'd5);
		bus_write(16'h4000, 8'd1);
		check_rom_read(16'h6001, banked_word(5, 16'h6001)); // 37 is beyond mask 31
		load_header(8'd1, 8'd6, 8'd0);                      // 2M rom with mask 127
		bus_write(16'h2000, 8'd5);
		bus_write(16'h4000, 8'd1);
		check_rom_read(16'h6001, banked_word(37, 16'h6001));
		bus_write(16'h6000, 8'd1);                          // mode 1
		check_rom_read(16'h6001, banked_word(5, 16'h6001));
		report_test("mbc1 rom banking", e);
	endtask

	task automatic test_mbc5_wide();
		int e;
		e = errors;
		load_header(8'd25, 8'd8, 8'd0); // 8M rom with mask 511
		bus_write(16'h2000, 8'h34);
		bus_write(16'h3000, 8'h01);
		check_rom_read(16'h4A55, banked_word('h134, 16'h4A55));
		bus_write(16'h2000, 8'h00);
		bus_write(16'h3000, 8'h00);
		check_rom_read(16'h4A55, banked_word(0, 16'h4A55)); // bank 0 is legal here
		report_test("mbc5 wide bank", e);
	endtask

	task automatic test_cart_ram();
		int         e;
		int         i;
		logic [7:0] b0 [4];
		logic [7:0] b3 [4];
		e = errors;
		load_header(8'd27, 8'd0, 8'd4); // mbc5 with 16 ram banks
		check_ram_read(16'hA000, 8'hFF); // still disabled
		bus_write(16'h0000, 8'h0A);
		for (i = 0; i < 4; i++) begin
			b0[i] = rand_byte();
			bus_write(16'hA000 + 16'(i), b0[i]);
		end
		bus_write(16'h4000, 8'd3);
		for (i = 0; i < 4; i++) begin
			b3[i] = rand_byte();
			bus_write(16'hA000 + 16'(i), b3[i]);
		end
		for (i = 0; i < 4; i++)
			check_ram_read(16'hA000 + 16'(i), b3[i]);
		bus_write(16'h4000, 8'd0);
		for (i = 0; i < 4; i++)
			check_ram_read(16'hA000 + 16'(i), b0[i]);
		bus_write(16'h0000, 8'h00);      // disable
		check_ram_read(16'hA001, 8'hFF);
		bus_write(16'hA001, ~b0[1]);     // must be dropped
		bus_write(16'h0000, 8'h0A);
		check_ram_read(16'hA001, b0[1]);
		report_test("cartridge ram", e);
	endtask

	task automatic test_rtc_nibble();
		int         e;
		logic [7:0] b;
		logic [7:0] c;
		e = errors;
		load_header(8'd16, 8'd0, 8'd3); // mbc3 with 4 ram banks
		bus_write(16'h0000, 8'h0A);
		b = rand_byte() | 8'h01;        // never 00 so the rtc read stands apart
		bus_write(16'hA100, b);
		bus_write(16'h4000, 8'h08);     // rtc register window
		check_ram_read(16'hA100, 8'h00);
		bus_write(16'h4000, 8'h00);
		check_ram_read(16'hA100, b);
		load_header(8'd5, 8'd1, 8'd0);  // mbc2
		bus_write(16'h0000, 8'h0A);
		c = rand_byte() & 8'h7F;        // upper nibble never F
		bus_write(16'hA010, c);
		check_ram_read(16'hA010, {4'hF, c[3:0]});
		report_test("mbc3 rtc and mbc2 nibble", e);
	endtask

	// ----------------------------------------------------------------------
	// sequence and timeout
	// ----------------------------------------------------------------------
	initial begin
		reset     = 1'b1;
		dl_active = 1'b0;
		dl_wr     = 1'b0;
		dl_addr   = '0;
		dl_data   = '0;
		bus_rd    = 1'b0;
		bus_wr    = 1'b0;
		bus_addr  = '0;
		bus_wdata = '0;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		test_no_mbc();
		test_mbc1_rom();
		test_mbc5_wide();
		test_cart_ram();
		test_rtc_nibble();
		@(negedge clk_sys);
		$display("tests passed %0d, failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: tests still running after %0d cycles", cycle_count);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

endmodule
